/* common/char_consts.svh */
`ifndef CHAR_CONSTS_SVH
`define CHAR_CONSTS_SVH

// word sizes
`define CHAR_PHY_W       16                       // unsigned coordinate width
`define CHAR_FRAC        8                        // velocity fraction bits
`define CHAR_OBST_NUM    7
`define CHAR_BLK_W       4                        // obstacle block count field

// map, x grows leftward
`define CHAR_FLOOR_Y     20
`define CHAR_RIGHT_LIM   160                      // lowest legal x
`define CHAR_LEFT_LIM    560                      // highest x plus box width

// character box and start point
`define CHAR_W           42
`define CHAR_H           50
`define CHAR_INIT_X      300
`define CHAR_INIT_Y      20

// obstacle geometry
`define OBST_BLK_W       10
`define OBST_H           20

// motion, all velocities in fixed point
`define CHAR_GRAVITY     256
`define CHAR_MAX_VEL     (58 << `CHAR_FRAC)       // below one obstacle plus box per tick
`define CHAR_JUMP_VX     (2 << `CHAR_FRAC)
`define CHAR_JUMP_VY     (6 << `CHAR_FRAC)
`define CHAR_CHARGE_STEP 10
`define CHAR_CHARGE_MAX  500

`endif

/* common/char_geom_pkg.sv */
`include "char_consts.svh"

package char_geom_pkg;

    // signed position or velocity, one bit above the map range
    typedef logic signed [`CHAR_PHY_W:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } vec2_t;

    typedef struct packed {
        vec2_t pos;
        vec2_t vel;                            // fixed point, CHAR_FRAC bits
    } kin_t;

    // spans blocks*OBST_BLK_W in x and OBST_H in y from (x, y)
    typedef struct packed {
        logic [`CHAR_PHY_W-1:0] x;
        logic [`CHAR_PHY_W-1:0] y;
        logic [`CHAR_BLK_W-1:0] blocks;        // 0 means no obstacle
    } obstacle_t;

    typedef struct packed {
        logic   overlap;
        logic   support;                       // standing on its top
        logic   from_side;
        logic   from_below;
        coord_t snap;                          // corrected x or y
    } probe_t;

endpackage

/* common/char_ctrl_pkg.sv */
package char_ctrl_pkg;

    typedef struct packed {
        logic left;                            // toward +x
        logic right;
        logic jump;
    } buttons_t;

    typedef enum logic [2:0] {
        IDLE       = 3'd0,
        WALK_LEFT  = 3'd1,
        WALK_RIGHT = 3'd2,
        CHARGE     = 3'd3,
        JUMP       = 3'd4,
        BUMP       = 3'd5
    } motion_state_e;

    typedef enum logic [1:0] {
        COL_NONE,
        COL_FROM_BELOW,
        COL_FROM_ABOVE,
        COL_SIDE
    } collision_e;

    typedef struct packed {
        collision_e            kind;
        logic                  on_ground;
        char_geom_pkg::coord_t snap;           // x for COL_SIDE, y otherwise
    } contact_t;

endpackage

/* collision/obstacle_probe.sv */
`timescale 1ns/1ps
`include "char_consts.svh"

module obstacle_probe (
    input  char_geom_pkg::kin_t      kin,
    input  char_geom_pkg::vec2_t     prev_pos,
    input  char_geom_pkg::obstacle_t obstacle,
    output char_geom_pkg::probe_t    probe
);
    import char_geom_pkg::*;

    localparam coord_t CW    = coord_t'(`CHAR_W);
    localparam coord_t CH    = coord_t'(`CHAR_H);
    localparam coord_t BLK_W = coord_t'(`OBST_BLK_W);
    localparam coord_t OBS_H = coord_t'(`OBST_H);

    coord_t ox;
    coord_t oy;
    coord_t ox_end;                          // first column past the obstacle
    coord_t oy_end;                          // first row above it
    logic   x_ovl;
    logic   y_ovl;
    logic   prev_low;                        // was fully below ox
    logic   prev_high;                       // was fully past ox_end
    logic   side;
    logic   below;

    assign ox     = coord_t'(obstacle.x);
    assign oy     = coord_t'(obstacle.y);
    assign ox_end = ox + coord_t'(obstacle.blocks) * BLK_W;
    assign oy_end = oy + OBS_H;

    assign x_ovl     = (obstacle.blocks != '0) && (kin.pos.x < ox_end) && (kin.pos.x + CW > ox);
    assign y_ovl     = (kin.pos.y < oy_end) && (kin.pos.y + CH > oy);
    assign prev_low  = (prev_pos.x + CW <= ox);
    assign prev_high = (prev_pos.x >= ox_end);
    assign side      = prev_low || prev_high;
    assign below     = !side && (kin.vel.y > coord_t'(0));  // still rising

    assign probe.overlap    = x_ovl && y_ovl;
    assign probe.support    = x_ovl && (kin.pos.y == oy_end);
    assign probe.from_side  = side;
    assign probe.from_below = below;
    assign probe.snap       = side  ? (prev_low ? ox - CW : ox_end) :
                              below ? oy - CH : oy_end;

endmodule

/* collision/collision_resolver.sv */
`timescale 1ns/1ps
`include "char_consts.svh"

module collision_resolver (
    input  logic                    sys_clk,
    input  logic                    sys_rst_n,
    input  char_geom_pkg::kin_t     kin,
    input  char_geom_pkg::probe_t   probes [`CHAR_OBST_NUM],
    output char_ctrl_pkg::contact_t contact
);
    import char_geom_pkg::*;
    import char_ctrl_pkg::*;

    localparam coord_t FLOOR_Y = coord_t'(`CHAR_FLOOR_Y);

    probe_t   hit;                           // winning probe, all zero if none
    logic     support_any;
    contact_t contact_n;

    // ------------------------------------------------------------------
    // priority pick, lowest index wins
    // ------------------------------------------------------------------
    always_comb begin
        hit         = '0;
        support_any = 1'b0;
        for (int i = `CHAR_OBST_NUM - 1; i >= 0; i--) begin
            if (probes[i].overlap) begin
                hit = probes[i];
            end
            support_any = support_any | probes[i].support;
        end
    end

    always_comb begin
        if (!hit.overlap) begin
            contact_n.kind = COL_NONE;
        end else if (hit.from_side) begin
            contact_n.kind = COL_SIDE;
        end else if (hit.from_below) begin
            contact_n.kind = COL_FROM_BELOW;
        end else begin
            contact_n.kind = COL_FROM_ABOVE;
        end
        contact_n.on_ground = (kin.pos.y == FLOOR_Y) || support_any;
        contact_n.snap      = hit.snap;
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            contact <= '{kind: COL_NONE, on_ground: 1'b0, snap: '0};
        end else begin
            contact <= contact_n;
        end
    end

    // support on one obstacle while bumping another from below is a broken map
    a_ground_vs_below: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        !(contact.on_ground && contact.kind == COL_FROM_BELOW));

endmodule

/* design/motion_fsm.sv */
`timescale 1ns/1ps
`include "char_consts.svh"

module motion_fsm (
    input  logic                         sys_clk,
    input  logic                         sys_rst_n,
    input  logic                         tick,
    input  char_ctrl_pkg::buttons_t      btn,
    input  char_ctrl_pkg::contact_t      contact,
    output char_ctrl_pkg::motion_state_e state,
    output logic [`CHAR_PHY_W-1:0]       charge
);
    import char_ctrl_pkg::*;

    typedef logic [`CHAR_PHY_W-1:0] charge_t;

    localparam charge_t CHARGE_STEP = charge_t'(`CHAR_CHARGE_STEP);
    localparam charge_t CHARGE_MAX  = charge_t'(`CHAR_CHARGE_MAX);

    buttons_t      btn_q;                     // sampled levels
    logic          jump_pend;                 // press seen while on ground
    motion_state_e state_n;

    // ------------------------------------------------------------------
    // button sampling
    // ------------------------------------------------------------------
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            btn_q     <= '0;
            jump_pend <= 1'b0;
        end else begin
            btn_q <= btn;
            if (btn.jump && !btn_q.jump && contact.on_ground) begin
                jump_pend <= 1'b1;
            end else if (state == JUMP) begin
                jump_pend <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // state machine, advances on tick only
    // ------------------------------------------------------------------
    always_comb begin
        state_n = IDLE;
        if (contact.kind != COL_NONE) begin
            state_n = BUMP;
        end else begin
            case (state)
                IDLE, WALK_LEFT, WALK_RIGHT: begin
                    if (contact.on_ground) begin  // no steering in the air
                        if (btn_q.left) begin
                            state_n = WALK_LEFT;
                        end else if (btn_q.right) begin
                            state_n = WALK_RIGHT;
                        end else if (jump_pend) begin
                            state_n = CHARGE;
                        end
                    end
                end
                CHARGE: begin
                    if (!btn_q.jump || charge >= CHARGE_MAX) begin
                        state_n = JUMP;
                    end else begin
                        state_n = CHARGE;
                    end
                end
                default: state_n = IDLE;           // JUMP and BUMP last one tick
            endcase
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state <= IDLE;
        end else if (tick) begin
            state <= state_n;
        end
    end

    // charge counter, saturates at the cap
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            charge <= '0;
        end else if (tick) begin
            if (state == CHARGE && charge < CHARGE_MAX) begin
                charge <= charge + CHARGE_STEP;
            end else if (state == JUMP) begin
                charge <= '0;
            end
        end
    end

    // contact settles two cycles after kin moves, so ticks need a gap
    a_tick_gap: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        tick |=> !tick [*2]);

endmodule

/* design/physics_integrator.sv */
`timescale 1ns/1ps
`include "char_consts.svh"

module physics_integrator (
    input  logic                         sys_clk,
    input  logic                         sys_rst_n,
    input  logic                         tick,
    input  char_ctrl_pkg::motion_state_e state,
    input  logic [`CHAR_PHY_W-1:0]       charge,
    input  char_ctrl_pkg::contact_t      contact,
    output char_geom_pkg::kin_t          kin,
    output char_geom_pkg::vec2_t         prev_pos,
    output logic                         face
);
    import char_geom_pkg::*;
    import char_ctrl_pkg::*;

    localparam coord_t MAX_VEL   = coord_t'(`CHAR_MAX_VEL);
    localparam coord_t GRAVITY   = coord_t'(`CHAR_GRAVITY);
    localparam coord_t JUMP_VX   = coord_t'(`CHAR_JUMP_VX);
    localparam coord_t JUMP_VY   = coord_t'(`CHAR_JUMP_VY);
    localparam coord_t WALK_STEP = coord_t'(1);
    localparam coord_t LO_X      = coord_t'(`CHAR_RIGHT_LIM);
    localparam coord_t HI_X      = coord_t'(`CHAR_LEFT_LIM - `CHAR_W);
    localparam coord_t FLOOR_Y   = coord_t'(`CHAR_FLOOR_Y);
    localparam vec2_t  INIT_POS  = '{x: coord_t'(`CHAR_INIT_X), y: coord_t'(`CHAR_INIT_Y)};

    coord_t charge_s;                        // zero-extended charge
    coord_t launch_x;
    vec2_t  vel_n;
    vec2_t  pos_n;

    function automatic coord_t limit_vel(input coord_t v);
        if (v > MAX_VEL) begin
            return MAX_VEL;
        end else if (v < -MAX_VEL) begin
            return -MAX_VEL;
        end
        return v;
    endfunction

    assign charge_s = coord_t'(charge);
    assign launch_x = JUMP_VX + charge_s;

    // ------------------------------------------------------------------
    // velocity, launch and gravity first, then the collision response
    // ------------------------------------------------------------------
    always_comb begin
        vel_n = kin.vel;
        if (state == JUMP) begin
            vel_n.y = JUMP_VY + (charge_s <<< 2) - GRAVITY;
            vel_n.x = face ? launch_x : -launch_x;
        end else if (!contact.on_ground) begin
            vel_n.y = kin.vel.y - GRAVITY;
        end else begin
            vel_n = '0;                            // resting
        end
        case (contact.kind)
            COL_FROM_BELOW: vel_n.y = '0;
            COL_FROM_ABOVE: vel_n   = '0;
            COL_SIDE:       vel_n.x = -vel_n.x;    // bounce off
            default:        ;
        endcase
        vel_n.x = limit_vel(vel_n.x);
        vel_n.y = limit_vel(vel_n.y);
    end

    // ------------------------------------------------------------------
    // position, walk steps are whole pixels
    // ------------------------------------------------------------------
    always_comb begin
        pos_n.x = kin.pos.x + (vel_n.x >>> `CHAR_FRAC);
        pos_n.y = kin.pos.y + (vel_n.y >>> `CHAR_FRAC);
        if (state == WALK_LEFT) begin
            pos_n.x = kin.pos.x + WALK_STEP;
        end else if (state == WALK_RIGHT) begin
            pos_n.x = kin.pos.x - WALK_STEP;
        end
        case (contact.kind)
            COL_SIDE:                       pos_n.x = contact.snap;
            COL_FROM_BELOW, COL_FROM_ABOVE: pos_n.y = contact.snap;
            default:                        ;
        endcase
        // walls and floor only clamp
        if (pos_n.x < LO_X) begin
            pos_n.x = LO_X;
        end else if (pos_n.x > HI_X) begin
            pos_n.x = HI_X;
        end
        if (pos_n.y < FLOOR_Y) begin
            pos_n.y = FLOOR_Y;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            kin.pos  <= INIT_POS;
            kin.vel  <= '0;
            prev_pos <= INIT_POS;
            face     <= 1'b1;
        end else if (tick) begin
            kin.pos  <= pos_n;
            kin.vel  <= vel_n;
            prev_pos <= kin.pos;               // probes use it to tell side hits
            if (contact.kind == COL_SIDE) begin
                face <= ~face;
            end else if (state == WALK_LEFT) begin
                face <= 1'b1;
            end else if (state == WALK_RIGHT) begin
                face <= 1'b0;
            end
        end
    end

    // a vertical snap never puts the box under the floor
    a_above_floor: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        tick && (contact.kind == COL_FROM_BELOW || contact.kind == COL_FROM_ABOVE)
            |-> contact.snap >= FLOOR_Y);

endmodule

/* design/character_top.sv */
`timescale 1ns/1ps
`include "char_consts.svh"

module character_top (
    input  logic                         sys_clk,
    input  logic                         sys_rst_n,
    input  logic                         tick,        // one-cycle game step
    input  char_ctrl_pkg::buttons_t      btn,
    input  char_geom_pkg::obstacle_t     obstacles [`CHAR_OBST_NUM],
    output char_geom_pkg::kin_t          kin,
    output logic                         face,
    output char_ctrl_pkg::motion_state_e state,
    output logic [`CHAR_PHY_W-1:0]       charge
);
    import char_geom_pkg::*;
    import char_ctrl_pkg::*;

    vec2_t    prev_pos;
    probe_t   probes [`CHAR_OBST_NUM];
    contact_t contact;                       // registered, lags kin by two cycles

    motion_fsm u_fsm (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tick      (tick),
        .btn       (btn),
        .contact   (contact),
        .state     (state),
        .charge    (charge)
    );

    physics_integrator u_phys (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tick      (tick),
        .state     (state),
        .charge    (charge),
        .contact   (contact),
        .kin       (kin),
        .prev_pos  (prev_pos),
        .face      (face)
    );

    // ------------------------------------------------------------------
    // one probe per obstacle, all in parallel
    // ------------------------------------------------------------------
    for (genvar i = 0; i < `CHAR_OBST_NUM; i++) begin : g_probe
        obstacle_probe u_probe (
            .kin      (kin),
            .prev_pos (prev_pos),
            .obstacle (obstacles[i]),
            .probe    (probes[i])
        );
    end

    collision_resolver u_resolve (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .kin       (kin),
        .probes    (probes),
        .contact   (contact)
    );

endmodule

/* verif/character_tb.sv */
`timescale 1ns/1ps
`include "char_consts.svh"

module character_tb;
    import char_geom_pkg::*;
    import char_ctrl_pkg::*;

    localparam int NUM_ROWS   = 9;
    localparam int INIT_X     = `CHAR_INIT_X;
    localparam int FLOOR_Y    = `CHAR_FLOOR_Y;
    localparam int LO_X       = `CHAR_RIGHT_LIM;
    localparam int HI_X       = `CHAR_LEFT_LIM - `CHAR_W;
    localparam int BUMP_X     = `CHAR_INIT_X + `CHAR_W + 5;     // obstacle just ahead
    localparam int CEIL_Y     = 100;
    localparam int CEIL_LIMIT = CEIL_Y - `CHAR_H + (`CHAR_MAX_VEL >> `CHAR_FRAC);
    localparam int SETTLE     = 60;                              // ticks to land

    typedef enum {M_REST, M_CHARGE, M_LAUNCH, M_AIR} jump_phase_e;

    // one scenario, replayed from reset
    typedef struct packed {
        logic [1:0]    obst_set;
        buttons_t      btn;
        logic [15:0]   hold;                 // ticks with btn held
        logic [15:0]   settle;               // ticks after release
        kin_t          exp_kin;
        kin_t          kin_mask;
        logic          exp_face;
        motion_state_e exp_state;
        logic [15:0]   ceiling;              // 0 means unchecked
    } row_t;

    logic                   sys_clk;
    logic                   sys_rst_n;
    logic                   tick;
    buttons_t               btn;
    obstacle_t              obstacles [`CHAR_OBST_NUM];
    kin_t                   kin;
    logic                   face;
    motion_state_e          state;
    logic [`CHAR_PHY_W-1:0] charge;

    row_t        rows [NUM_ROWS];
    logic [31:0] lcg_state;
    longint      budget_ns = 0;

    character_top dut (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tick      (tick),
        .btn       (btn),
        .obstacles (obstacles),
        .kin       (kin),
        .face      (face),
        .state     (state),
        .charge    (charge)
    );

    always #2 sys_clk = ~sys_clk;

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fail_now(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_kin(input kin_t got, input kin_t exp, input kin_t mask,
                             input string what);
        string got_s;
        string exp_s;
        if (((got ^ exp) & mask) !== '0) begin
            got_s = $sformatf("pos (%0d,%0d) vel (%0d,%0d)",
                got.pos.x, got.pos.y, got.vel.x, got.vel.y);
            exp_s = $sformatf("pos (%0d,%0d) vel (%0d,%0d)",
                exp.pos.x, exp.pos.y, exp.vel.x, exp.vel.y);
            fail_now($sformatf("%s: kin %s, expected %s", what, got_s, exp_s));
        end
    endtask

    task automatic check_face(input logic got, input logic exp, input string what);
        if (got !== exp) fail_now($sformatf("%s: face %0b, expected %0b", what, got, exp));
    endtask

    task automatic check_state(input motion_state_e got, input motion_state_e exp,
                               input string what);
        if (got !== exp) begin
            fail_now($sformatf("%s: state %s, expected %s", what, got.name(), exp.name()));
        end
    endtask

    task automatic check_charge(input logic [`CHAR_PHY_W-1:0] got,
                                input logic [`CHAR_PHY_W-1:0] exp,
                                input string what);
        if (got !== exp) fail_now($sformatf("%s: charge %0d, expected %0d", what, got, exp));
    endtask

    function automatic row_t walk_row(input logic to_left, input int n);
        row_t r;
        int   x;
        r         = '0;
        x         = to_left ? INIT_X + n : INIT_X - n;  // one pixel per held tick
        x         = (x > HI_X) ? HI_X : (x < LO_X) ? LO_X : x;
        r.btn     = to_left ? 3'b100 : 3'b010;
        r.hold    = 16'(n);
        r.settle  = 16'd4;
        r.exp_kin.pos.x = coord_t'(x);
        r.exp_kin.pos.y = coord_t'(FLOOR_Y);
        r.kin_mask  = '1;
        r.exp_face  = to_left;
        r.exp_state = IDLE;
        return r;
    endfunction

    function automatic row_t jump_row(input int set, input int hold, input int ceiling);
        row_t r;
        r = '0;
        r.obst_set   = 2'(set);
        r.btn.jump   = 1'b1;
        r.hold       = 16'(hold);
        r.settle     = 16'(SETTLE);
        r.exp_kin.pos.y = coord_t'(FLOOR_Y);
        r.kin_mask   = '1;
        r.kin_mask.pos.x = '0;               // landing spot depends on flight time
        r.exp_face   = 1'b1;
        r.exp_state  = IDLE;
        r.ceiling    = 16'(ceiling);
        return r;
    endfunction

    task automatic load_obstacles(input int set);
        for (int i = 0; i < `CHAR_OBST_NUM; i++) obstacles[i] = '0;
        if (set == 1) begin
            obstacles[0] = '{x: 16'(BUMP_X), y: 16'(FLOOR_Y), blocks: 4'd3};
        end else if (set == 2) begin
            for (int i = 0; i < 3; i++) begin  // ceiling across the whole map
                obstacles[i] = '{x: 16'(150 + 150 * i), y: 16'(CEIL_Y), blocks: 4'd15};
            end
        end
    endtask

    task automatic apply_reset(input int set);
        sys_rst_n = 1'b0;
        tick      = 1'b0;
        btn       = '0;
        load_obstacles(set);
        repeat (5) @(posedge sys_clk);
        #1 sys_rst_n = 1'b1;
        repeat (4) @(posedge sys_clk);      // contact needs two cycles
        #1;
    endtask

    task automatic pulse_tick();
        repeat (7) @(posedge sys_clk);
        #1 tick = 1'b1;
        @(posedge sys_clk);
        #1 tick = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // one table row with a small model of the jump sequence
    // ----------------------------------------------------------------------
    task automatic run_row(input row_t r, input int idx);
        jump_phase_e            phase;
        logic [`CHAR_PHY_W-1:0] exp_charge;
        logic                   leave;
        logic                   hit_seen;
        int                     lx;
        kin_t                   launch;
        kin_t                   vel_mask;
        kin_t                   hit_exp;
        kin_t                   hit_mask;
        apply_reset(r.obst_set);
        btn        = r.btn;
        phase      = M_REST;
        exp_charge = '0;
        hit_seen   = 1'b0;
        for (int t = 1; t <= r.hold + r.settle; t++) begin
            pulse_tick();
            case (phase)
                M_REST: if (r.btn.jump && t == 1) begin
                    phase = M_CHARGE;
                    check_state(state, CHARGE, "jump press");
                    check_charge(charge, '0, "jump press");
                end
                M_CHARGE: begin
                    leave = (t > r.hold) || (exp_charge >= `CHAR_CHARGE_MAX);
                    if (exp_charge < `CHAR_CHARGE_MAX) exp_charge += `CHAR_CHARGE_STEP;
                    check_charge(charge, exp_charge, "charging");
                    check_state(state, leave ? JUMP : CHARGE, "charging");
                    if (leave) phase = M_LAUNCH;
                end
                M_LAUNCH: begin
                    lx            = `CHAR_JUMP_VX + exp_charge;
                    launch        = '0;
                    launch.vel.y  = coord_t'(`CHAR_JUMP_VY + 4 * exp_charge - `CHAR_GRAVITY);
                    launch.vel.x  = coord_t'(r.exp_face ? lx : -lx);
                    vel_mask      = '0;
                    vel_mask.vel  = '1;
                    check_kin(kin, launch, vel_mask, "launch");
                    phase = M_AIR;
                end
                default: ;
            endcase
            if (r.ceiling != 0 && kin.pos.y > coord_t'(r.ceiling)) begin
                fail_now($sformatf("row %0d: pos_y %0d above %0d", idx, kin.pos.y, r.ceiling));
            end
            // head against the ceiling, box snapped under it and stopped
            if (r.ceiling != 0 && state == BUMP) begin
                hit_seen       = 1'b1;
                hit_exp        = '0;
                hit_exp.pos.y  = coord_t'(CEIL_Y - `CHAR_H);
                hit_mask       = '0;
                hit_mask.pos.y = '1;
                hit_mask.vel.y = '1;
                check_kin(kin, hit_exp, hit_mask, $sformatf("row %0d ceiling hit", idx));
            end
            if (t == r.hold) btn = '0;
        end
        if (r.ceiling != 0 && !hit_seen) begin
            fail_now($sformatf("row %0d: the jump never hit the ceiling", idx));
        end
        check_kin(kin, r.exp_kin, r.kin_mask, $sformatf("row %0d end", idx));
        check_face(face, r.exp_face, $sformatf("row %0d end", idx));
        check_state(state, r.exp_state, $sformatf("row %0d end", idx));
        check_charge(charge, '0, $sformatf("row %0d end", idx));
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        sys_clk   = 1'b0;
        sys_rst_n = 1'b0;
        tick      = 1'b0;
        btn       = '0;
        load_obstacles(0);
        lcg_state = 32'h5d95;

        rows[0] = walk_row(1'b1, 0);          // plain reset values
        rows[0].btn    = '0;
        rows[0].settle = '0;
        lcg_state = lcg_next(lcg_state);
        rows[1] = walk_row(1'b1, (lcg_state >> 8) % 120 + 1);
        lcg_state = lcg_next(lcg_state);
        rows[2] = walk_row(1'b0, (lcg_state >> 8) % 120 + 1);
        rows[3] = walk_row(1'b1, 300);        // ends on a wall
        rows[4] = walk_row(1'b0, 300);
        rows[5] = jump_row(0, 3, 0);
        rows[6] = jump_row(0, 12, 0);
        rows[7] = walk_row(1'b1, 20);         // bump into the block
        rows[7].obst_set        = 2'd1;
        rows[7].exp_kin.pos.x   = coord_t'(BUMP_X - `CHAR_W);
        rows[7].exp_face        = 1'b0;
        rows[8] = jump_row(2, 60, CEIL_LIMIT); // full charge under a ceiling

        for (int i = 0; i < NUM_ROWS; i++) begin
            budget_ns += (rows[i].hold + rows[i].settle) * 8 * 4 + 12 * 4;
        end
        budget_ns += 2000;

        for (int i = 0; i < NUM_ROWS; i++) run_row(rows[i], i);
        $display("TEST RESULT: PASS");
        $finish;
    end

    // watchdog sized from the table
    initial begin
        wait (budget_ns > 0);
        #(budget_ns);
        $display("Timeout: the table did not finish within %0d ns", budget_ns);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

/* flist.f */
+incdir+common
common/char_geom_pkg.sv
common/char_ctrl_pkg.sv
collision/obstacle_probe.sv
collision/collision_resolver.sv
design/motion_fsm.sv
design/physics_integrator.sv
design/character_top.sv
verif/character_tb.sv

/* Bender.yml */
package:
  name: platform_character

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/char_geom_pkg.sv
      - common/char_ctrl_pkg.sv
      - collision/obstacle_probe.sv
      - collision/collision_resolver.sv
      - design/motion_fsm.sv
      - design/physics_integrator.sv
      - design/character_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/character_tb.sv
